// File: rtl/aud_pkg.sv
package aud_pkg;

    localparam int ADDR_W     = 20;
    localparam int SAMPLE_W   = 16;
    localparam int SPEED_W    = 4;

    // serializer timing, in i_clk cycles and bit clocks
    localparam int BCLK_DIV   = 2;
    localparam int FRAME_BITS = 32;
    localparam int DIV_W      = $clog2(BCLK_DIV);
    localparam int BCNT_W     = $clog2(FRAME_BITS);

    // floor(65535 / s), entry 0 unused
    localparam logic [15:0] RECIP [16] = '{
        16'h0000, 16'hFFFF, 16'h7FFF, 16'h5555,
        16'h3FFF, 16'h3333, 16'h2AAA, 16'h2492,
        16'h1FFF, 16'h1C71, 16'h1999, 16'h1745,
        16'h1555, 16'h13B1, 16'h1249, 16'h1111
    };

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PLAY    = 2'd1,
        ST_PAUSE   = 2'd2,
        ST_REVERSE = 2'd3
    } play_state_e;

    typedef struct packed {
        logic               start;
        logic               pause;
        logic               stop;
        logic               fast;     // skip samples instead of repeating
        logic               reverse;
        logic               interp;   // 1 for linear, 0 for constant
        logic [SPEED_W-1:0] speed;
        logic [ADDR_W-1:0]  end_addr;
    } play_ctrl_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic [ADDR_W-1:0] adr;
    } wb_req_t;

endpackage

// File: rtl/aud_dsp.sv
`timescale 1ns/1ps

module aud_dsp (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  aud_pkg::play_ctrl_t          i_ctrl,
    input  logic                         i_tick,
    input  logic [aud_pkg::SAMPLE_W-1:0] i_sample,
    output logic [aud_pkg::ADDR_W-1:0]   o_addr,
    output logic [aud_pkg::SAMPLE_W-1:0] o_sample,
    output logic                         o_playing
);

    aud_pkg::play_state_e state_q, state_d;

    logic [aud_pkg::ADDR_W-1:0]   addr_q, addr_d;
    logic [aud_pkg::SAMPLE_W-1:0] out_q, out_d;
    logic [aud_pkg::SAMPLE_W-1:0] prev_q, prev_d;
    logic [aud_pkg::SPEED_W-1:0]  cnt_q, cnt_d;

    logic [aud_pkg::SPEED_W-1:0]  step;
    logic [aud_pkg::ADDR_W:0]     fwd_next;
    logic                         past_end;
    logic                         below_zero;
    logic                         cnt_wrap;

    logic [31:0]                  prod_prev, prod_next;
    logic [aud_pkg::SPEED_W:0]    wt_prev, wt_next;
    logic [aud_pkg::ADDR_W:0]     lin_sum;
    logic [aud_pkg::SAMPLE_W-1:0] slow_out;

    assign step       = i_ctrl.fast ? i_ctrl.speed : aud_pkg::SPEED_W'(1);
    assign fwd_next   = {1'b0, addr_q} + (aud_pkg::ADDR_W + 1)'(step);
    assign past_end   = fwd_next > {1'b0, i_ctrl.end_addr};
    assign below_zero = addr_q < aud_pkg::ADDR_W'(i_ctrl.speed);
    assign cnt_wrap   = ({1'b0, cnt_q} + 5'd1) >= {1'b0, i_ctrl.speed};

    // linear blend of prev and the fetched word, each term scaled by 1/speed
    assign prod_prev = prev_q * aud_pkg::RECIP[i_ctrl.speed];
    assign prod_next = i_sample * aud_pkg::RECIP[i_ctrl.speed];
    assign wt_prev   = {1'b0, i_ctrl.speed} - {1'b0, cnt_q};
    assign wt_next   = {1'b0, cnt_q};
    assign lin_sum   = (aud_pkg::ADDR_W + 1)'(prod_prev[31:16]) * (aud_pkg::ADDR_W + 1)'(wt_prev)
                     + (aud_pkg::ADDR_W + 1)'(prod_next[31:16]) * (aud_pkg::ADDR_W + 1)'(wt_next);
    assign slow_out  = i_ctrl.interp ? lin_sum[aud_pkg::SAMPLE_W-1:0] : prev_q;

    always_comb begin
        state_d = state_q;
        addr_d  = addr_q;
        out_d   = out_q;
        prev_d  = prev_q;
        cnt_d   = cnt_q;

        if (state_q == aud_pkg::ST_IDLE) begin
            addr_d = '0;
            if (i_tick) out_d = '0;
            if (i_ctrl.start) begin  // leaves idle without waiting for a tick
                prev_d = i_sample;
                cnt_d  = '0;
                if (i_ctrl.reverse) begin
                    addr_d  = i_ctrl.end_addr;
                    state_d = aud_pkg::ST_REVERSE;
                end else begin
                    addr_d  = aud_pkg::ADDR_W'(step);
                    state_d = aud_pkg::ST_PLAY;
                end
            end
        end else if (i_tick) begin
            if (i_ctrl.stop) begin
                state_d = aud_pkg::ST_IDLE;
                addr_d  = '0;
                out_d   = '0;
                cnt_d   = '0;
            end else if (i_ctrl.pause) begin
                state_d = aud_pkg::ST_PAUSE;  // position frozen
                out_d   = '0;
            end else if (i_ctrl.reverse) begin
                state_d = aud_pkg::ST_REVERSE;
                out_d   = prev_q;
                prev_d  = i_sample;
                if (below_zero) begin
                    state_d = aud_pkg::ST_IDLE;
                    addr_d  = '0;
                end else begin
                    addr_d  = addr_q - aud_pkg::ADDR_W'(i_ctrl.speed);
                end
            end else if (i_ctrl.fast) begin
                state_d = aud_pkg::ST_PLAY;
                out_d   = prev_q;
                prev_d  = i_sample;
                if (past_end) begin
                    state_d = aud_pkg::ST_IDLE;
                    addr_d  = '0;
                end else begin
                    addr_d  = fwd_next[aud_pkg::ADDR_W-1:0];
                end
            end else begin
                state_d = aud_pkg::ST_PLAY;
                out_d   = slow_out;
                if (cnt_wrap) begin
                    cnt_d = '0;
                    if (past_end) begin
                        state_d = aud_pkg::ST_IDLE;
                        addr_d  = '0;
                    end else begin
                        addr_d = fwd_next[aud_pkg::ADDR_W-1:0];
                        prev_d = i_sample;
                    end
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= aud_pkg::ST_IDLE;
            addr_q  <= '0;
            out_q   <= '0;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            addr_q  <= addr_d;
            out_q   <= out_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge i_clk) begin
        prev_q <= prev_d;
    end

    assign o_addr    = addr_q;
    assign o_sample  = out_q;
    assign o_playing = (state_q == aud_pkg::ST_PLAY) || (state_q == aud_pkg::ST_REVERSE);

endmodule

// File: rtl/aud_sample_fetch.sv
`timescale 1ns/1ps

module aud_sample_fetch (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic [aud_pkg::ADDR_W-1:0]   i_addr,
    output aud_pkg::wb_req_t             o_wb,
    input  logic [aud_pkg::SAMPLE_W-1:0] i_wb_dat,
    input  logic                         i_wb_ack,
    output logic [aud_pkg::SAMPLE_W-1:0] o_sample,
    output logic                         o_sample_vld
);

    aud_pkg::wb_req_t wb_q;

    logic [aud_pkg::ADDR_W-1:0]   last_addr_q;
    logic [aud_pkg::SAMPLE_W-1:0] sample_q;
    logic                         have_q;   // last_addr_q holds a fetched address
    logic                         vld_q;
    logic                         need;
    logic                         done;

    assign need = !have_q || (i_addr != last_addr_q);
    assign done = wb_q.cyc && i_wb_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_q   <= '0;
            have_q <= 1'b0;
            vld_q  <= 1'b0;
        end else begin
            vld_q <= done;
            if (wb_q.cyc) begin
                if (i_wb_ack) begin  // data taken this cycle
                    wb_q.cyc <= 1'b0;
                    wb_q.stb <= 1'b0;
                    have_q   <= 1'b1;
                end
            end else if (need) begin
                wb_q.cyc <= 1'b1;
                wb_q.stb <= 1'b1;
                wb_q.adr <= i_addr;  // held until ack
            end
        end
    end

    // a change of i_addr during the cycle is picked up after the ack
    always_ff @(posedge i_clk) begin
        if (done) begin
            sample_q    <= i_wb_dat;
            last_addr_q <= wb_q.adr;
        end
    end

    assign o_wb         = wb_q;
    assign o_sample     = sample_q;
    assign o_sample_vld = vld_q;

endmodule

// File: rtl/aud_i2s_tx.sv
`timescale 1ns/1ps

module aud_i2s_tx (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic [aud_pkg::SAMPLE_W-1:0] i_sample,
    output logic                         o_bclk,
    output logic                         o_lrck,
    output logic                         o_sdata,
    output logic                         o_frame_tick
);

    logic [aud_pkg::DIV_W-1:0]    div_q;
    logic [aud_pkg::BCNT_W-1:0]   bit_q;
    logic [aud_pkg::SAMPLE_W-1:0] shift_q;
    logic [aud_pkg::SAMPLE_W-1:0] hold_q;   // replayed in the right half
    logic                         bclk_q;
    logic                         tick_q;

    logic                         div_wrap;
    logic                         bclk_fall;
    logic                         frame_end;
    logic                         half_end;

    assign div_wrap  = div_q == aud_pkg::DIV_W'(aud_pkg::BCLK_DIV - 1);
    assign bclk_fall = div_wrap && bclk_q;
    assign frame_end = bit_q == aud_pkg::BCNT_W'(aud_pkg::FRAME_BITS - 1);
    assign half_end  = bit_q == aud_pkg::BCNT_W'(aud_pkg::FRAME_BITS / 2 - 1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_q  <= '0;
            bclk_q <= 1'b0;
            bit_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            tick_q <= bclk_fall && frame_end;  // high while lrck is newly low
            div_q  <= div_wrap ? '0 : div_q + 1'b1;
            if (div_wrap) bclk_q <= ~bclk_q;
            if (bclk_fall) bit_q <= bit_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shift_q <= '0;
            hold_q  <= '0;
        end else if (bclk_fall) begin
            if (frame_end) begin
                shift_q <= i_sample;  // dsp output before this tick
                hold_q  <= i_sample;
            end else if (half_end) begin
                shift_q <= hold_q;
            end else begin
                shift_q <= shift_q << 1;
            end
        end
    end

    assign o_bclk       = bclk_q;
    assign o_lrck       = bit_q[aud_pkg::BCNT_W-1];
    assign o_sdata      = shift_q[aud_pkg::SAMPLE_W-1];  // msb first
    assign o_frame_tick = tick_q;

endmodule

// File: rtl/aud_player_top.sv
`timescale 1ns/1ps

module aud_player_top (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    input  logic                         i_pause,
    input  logic                         i_stop,
    input  logic                         i_fast,
    input  logic                         i_reverse,
    input  logic                         i_interp,
    input  logic [3:0]                   i_speed,
    input  logic [aud_pkg::ADDR_W-1:0]   i_end_addr,
    output logic                         o_wb_cyc,
    output logic                         o_wb_stb,
    output logic [aud_pkg::ADDR_W-1:0]   o_wb_adr,
    input  logic [aud_pkg::SAMPLE_W-1:0] i_wb_dat,
    input  logic                         i_wb_ack,
    output logic                         o_bclk,
    output logic                         o_lrck,
    output logic                         o_sdata,
    output logic                         o_playing
);

    aud_pkg::play_ctrl_t ctrl;
    aud_pkg::wb_req_t    wb_req;

    logic [aud_pkg::ADDR_W-1:0]   play_addr;
    logic [aud_pkg::SAMPLE_W-1:0] fetched;
    logic [aud_pkg::SAMPLE_W-1:0] dsp_out;
    logic                         frame_tick;

    assign ctrl = '{
        start:    i_start,
        pause:    i_pause,
        stop:     i_stop,
        fast:     i_fast,
        reverse:  i_reverse,
        interp:   i_interp,
        speed:    i_speed,
        end_addr: i_end_addr
    };

    aud_dsp u_dsp (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_ctrl    (ctrl),
        .i_tick    (frame_tick),
        .i_sample  (fetched),
        .o_addr    (play_addr),
        .o_sample  (dsp_out),
        .o_playing (o_playing)
    );

    aud_sample_fetch u_fetch (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_addr       (play_addr),
        .o_wb         (wb_req),
        .i_wb_dat     (i_wb_dat),
        .i_wb_ack     (i_wb_ack),
        .o_sample     (fetched),
        .o_sample_vld ()
    );

    aud_i2s_tx u_i2s (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_sample     (dsp_out),
        .o_bclk       (o_bclk),
        .o_lrck       (o_lrck),
        .o_sdata      (o_sdata),
        .o_frame_tick (frame_tick)
    );

    assign o_wb_cyc = wb_req.cyc;
    assign o_wb_stb = wb_req.stb;
    assign o_wb_adr = wb_req.adr;

endmodule

// File: dv/aud_player_checker.sv
`timescale 1ns/1ps

module aud_player_checker (
    input logic                       i_clk,
    input logic                       i_rst_n,
    input logic                       o_wb_cyc,
    input logic                       o_wb_stb,
    input logic [aud_pkg::ADDR_W-1:0] o_wb_adr,
    input logic                       i_wb_ack,
    input logic                       o_lrck
);

    logic       lrck_q;
    logic       lrck_chg;
    logic       armed_q;   // first lrck change seen
    logic [7:0] since_q;   // cycles since the last lrck change

    assign lrck_chg = o_lrck != lrck_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_q  <= 1'b0;
            armed_q <= 1'b0;
            since_q <= '0;
        end else begin
            lrck_q  <= o_lrck;
            armed_q <= armed_q | lrck_chg;
            since_q <= lrck_chg ? 8'd0 : since_q + 8'd1;
        end
    end

    a_stb_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)))
        else $error("stb dropped or address moved before ack");

    a_cyc_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_cyc == o_wb_stb)
        else $error("cyc and stb differ");

    a_lrck_period: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (lrck_chg && armed_q) |-> (since_q == 8'd63))
        else $error("lrck half period is not 64 cycles");

endmodule

bind aud_player_top aud_player_checker u_checker (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .o_wb_cyc (o_wb_cyc),
    .o_wb_stb (o_wb_stb),
    .o_wb_adr (o_wb_adr),
    .i_wb_ack (i_wb_ack),
    .o_lrck   (o_lrck)
);

// File: dv/aud_player_tb.sv
`timescale 1ns/1ps

module aud_player_tb;

    logic        i_clk = 1'b0;
    logic        i_rst_n = 1'b0;
    logic        i_start = 1'b0, i_pause = 1'b0, i_stop = 1'b0;
    logic        i_fast = 1'b0, i_reverse = 1'b0, i_interp = 1'b0;
    logic [3:0]  i_speed = 4'd1;
    logic [19:0] i_end_addr = '0;
    logic        o_wb_cyc, o_wb_stb, o_bclk, o_lrck, o_sdata, o_playing;
    logic [19:0] o_wb_adr;
    logic [15:0] i_wb_dat = '0;
    logic        i_wb_ack = 1'b0;

    logic [31:0] lfsr = 32'h55f3_3a20;
    logic        rst_done = 1'b0;
    logic        mem_busy = 1'b0;
    logic [3:0]  wait_left = '0;
    logic [15:0] exp_q[$];
    logic [15:0] cap = '0;
    int          nbits = 0;

    // reference model state
    aud_pkg::play_state_e m_state = aud_pkg::ST_IDLE;
    logic [19:0] m_addr = '0;
    logic [15:0] m_out = '0, m_prev = '0;
    logic [3:0]  m_cnt = '0;

    aud_player_top u_aud_player_top (.*);

    always #5 i_clk = ~i_clk;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic [3:0] lfsr_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[2:0], lfsr[0]};  // one step per bit
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [15:0] mem_word(input logic [19:0] a);
        return (a[15:0] * 16'h2b67) ^ {a[19:16], a[11:0]} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] blend(input logic [15:0] p, input logic [15:0] n,
                                          input logic [3:0] s, input logic [3:0] c);
        int unsigned r, tp, tn;
        r  = (s == 0) ? 0 : 65535 / s;
        tp = (p * r) >> 16;
        tn = (n * r) >> 16;
        return 16'(tp * (s - c) + tn * c);
    endfunction

    function automatic void model_start();
        m_prev = mem_word(20'd0);
        m_cnt  = '0;
        if (i_reverse) begin
            m_addr  = i_end_addr;
            m_state = aud_pkg::ST_REVERSE;
        end else begin
            m_addr  = i_fast ? 20'(i_speed) : 20'd1;
            m_state = aud_pkg::ST_PLAY;
        end
    endfunction

    function automatic void model_tick();
        logic [15:0] word;
        logic        to_idle;
        word    = mem_word(m_addr);
        to_idle = 1'b0;
        if (m_state == aud_pkg::ST_IDLE) begin
            m_out = '0;
        end else if (i_stop) begin
            to_idle = 1'b1;
            m_out   = '0;
        end else if (i_pause) begin
            m_state = aud_pkg::ST_PAUSE;
            m_out   = '0;
        end else if (i_reverse || i_fast) begin
            m_state = i_reverse ? aud_pkg::ST_REVERSE : aud_pkg::ST_PLAY;
            m_out   = m_prev;
            m_prev  = word;
            if (i_reverse && m_addr < 20'(i_speed)) to_idle = 1'b1;
            else if (i_reverse) m_addr = m_addr - 20'(i_speed);
            else if (21'(m_addr) + 21'(i_speed) > 21'(i_end_addr)) to_idle = 1'b1;
            else m_addr = m_addr + 20'(i_speed);
        end else begin
            m_state = aud_pkg::ST_PLAY;
            m_out   = i_interp ? blend(m_prev, word, i_speed, m_cnt) : m_prev;
            if (5'(m_cnt) + 5'd1 >= 5'(i_speed)) begin  // repeat count done
                m_cnt = '0;
                if (21'(m_addr) + 21'd1 > 21'(i_end_addr)) begin
                    to_idle = 1'b1;
                end else begin
                    m_addr = m_addr + 20'd1;
                    m_prev = word;
                end
            end else begin
                m_cnt = m_cnt + 4'd1;
            end
        end
        if (to_idle) begin
            m_state = aud_pkg::ST_IDLE;
            m_addr  = '0;
            m_cnt   = '0;
        end
    endfunction

    // wishbone memory with random wait states
    always @(negedge i_clk) begin
        if (i_wb_ack) begin
            i_wb_ack = 1'b0;
        end else if (o_wb_cyc && o_wb_stb) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                wait_left = lfsr_bits(4);
            end
            if (wait_left == 0) begin
                i_wb_ack = 1'b1;
                i_wb_dat = mem_word(o_wb_adr);
                mem_busy = 1'b0;
            end else begin
                wait_left = wait_left - 4'd1;
            end
        end
    end

    always @(negedge o_lrck) begin
        if (rst_done) begin
            exp_q.push_back(m_out);  // frame n carries the output before tick n
            model_tick();
            @(negedge i_clk);
            @(negedge i_clk);
            check_value("o_playing", 32'(o_playing),
                        32'(m_state == aud_pkg::ST_PLAY || m_state == aud_pkg::ST_REVERSE));
        end
    end

    always @(posedge o_bclk) begin
        if (!o_lrck) begin
            cap   = {cap[14:0], o_sdata};
            nbits = nbits + 1;
            if (nbits == 16) begin
                nbits = 0;
                if (exp_q.size() == 0) fail_now("a frame arrived with no expected sample");
                check_value("o_sdata", 32'(cap), 32'(exp_q.pop_front()));
            end
        end
    end

    task automatic wait_frame();
        int  n;
        logic last;
        n    = 0;
        last = o_lrck;
        forever begin
            @(negedge i_clk);
            if (last && !o_lrck) break;
            last = o_lrck;
            n++;
            if (n > 200) fail_now("timed out waiting for a frame start");
        end
        @(negedge i_clk);  // past the tick edge
    endtask

    task automatic run_frames(input int k);
        repeat (k) wait_frame();
    endtask

    task automatic start_play(input logic fast, input logic rev, input logic interp,
                              input logic [3:0] speed, input logic [19:0] end_addr);
        wait_frame();
        i_fast     = fast;
        i_reverse  = rev;
        i_interp   = interp;
        i_speed    = speed;
        i_end_addr = end_addr;
        repeat (20) @(negedge i_clk);  // word at address 0 fetched by now
        i_start = 1'b1;
        model_start();
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic wait_idle(input int max_frames);
        int n;
        n = 0;
        while (o_playing) begin
            @(negedge i_clk);
            n++;
            if (n > max_frames * 128 + 256) fail_now("playback did not return to idle");
        end
        run_frames(2);
    endtask

    initial begin
        #5ms;
        fail_now("simulation watchdog expired");
    end

    initial begin
        exp_q.push_back(16'h0000);  // frame before the first tick
        repeat (4) @(negedge i_clk);
        i_rst_n  = 1'b1;
        rst_done = 1'b1;
        run_frames(3);
        start_play(1'b0, 1'b0, 1'b0, 4'd1, 20'd12);
        wait_idle(16);
        start_play(1'b1, 1'b0, 1'b0, 4'd2, 20'd60);
        wait_idle(34);
        start_play(1'b1, 1'b0, 1'b0, 4'd5, 20'd60);
        wait_idle(16);
        start_play(1'b1, 1'b0, 1'b0, 4'd15, 20'd60);
        wait_idle(8);
        start_play(1'b0, 1'b0, 1'b0, 4'd3, 20'd6);
        wait_idle(25);
        start_play(1'b0, 1'b0, 1'b1, 4'd4, 20'd5);
        wait_idle(28);
        start_play(1'b1, 1'b1, 1'b0, 4'd3, 20'd30);
        wait_idle(14);
        start_play(1'b0, 1'b0, 1'b0, 4'd1, 20'd40);
        run_frames(4);
        i_pause = 1'b1;
        run_frames(3);
        i_pause = 1'b0;
        run_frames(3);
        i_stop = 1'b1;
        run_frames(1);
        i_stop = 1'b0;
        wait_idle(2);
        start_play(1'b0, 1'b0, 1'b0, 4'd1, 20'd8);
        wait_idle(12);
        if (exp_q.size() > 1) begin
            fail_now("captured frames fell behind the reference model");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: verilog.f
rtl/aud_pkg.sv
rtl/aud_dsp.sv
rtl/aud_sample_fetch.sv
rtl/aud_i2s_tx.sv
rtl/aud_player_top.sv
dv/aud_player_checker.sv
dv/aud_player_tb.sv

// File: Makefile
SIM   := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := aud_player_tb
FLIST := verilog.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf obj_dir
